// ==== src/dnc_gate_pkg.sv ====
// Shared definitions for the DNC interface gate unit
package dnc_gate_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Which interface gate a scalar belongs to
  typedef logic [1:0] gate_id_t;

  ////////////////////////////////////////////////////////////////////////////
  // Gate codes
  ////////////////////////////////////////////////////////////////////////////

  // Write gate g^w
  localparam gate_id_t GATE_WRITE = 2'd0;

  // Allocation gate g^a
  localparam gate_id_t GATE_ALLOC = 2'd1;

  // Free gate f
  localparam gate_id_t GATE_FREE = 2'd2;

  // Code 3 is not a gate and is rejected by decode

  // Number of held gate levels
  localparam int GATE_COUNT = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Default fixed-point format
  ////////////////////////////////////////////////////////////////////////////

  // Total scalar width, two's complement
  localparam int DEFAULT_DATA_SIZE = 32;

  // Fraction bits within the scalar
  localparam int DEFAULT_FRAC_SIZE = 16;

endpackage

// ==== src/dnc_gate_decode.sv ====
`timescale 1ns/1ns

module dnc_gate_decode #(
  parameter int DATA_SIZE = 32,
  parameter int FRAC_SIZE = 16
) (
  // Global
  input  logic                   CLK,
  input  logic                   rst_n,

  // Host issue
  input  logic                   start,
  input  dnc_gate_pkg::gate_id_t gate_sel,
  input  logic [DATA_SIZE-1:0]   gate_in,

  // To the logistic pipeline
  output logic                   issue,
  output dnc_gate_pkg::gate_id_t issue_gate,
  output logic [DATA_SIZE-1:0]   issue_data,

  // Illegal selector strobe
  output logic                   error
);

  ////////////////////////////////////////////////////////////////////////////
  // Format check
  ////////////////////////////////////////////////////////////////////////////

  // Breakpoint 2.375 needs 3 fraction bits, offset 0.84375 needs 5
  // Value 5 needs 3 integer bits plus sign
  if (FRAC_SIZE < 5 || DATA_SIZE - FRAC_SIZE < 4) begin : g_bad_format
    $error("dnc_gate_decode: unsupported fixed-point format");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Selector check
  ////////////////////////////////////////////////////////////////////////////

  logic sel_legal;

  // Only the three gate codes are accepted
  assign sel_legal = (gate_sel == dnc_gate_pkg::GATE_WRITE) ||
                     (gate_sel == dnc_gate_pkg::GATE_ALLOC) ||
                     (gate_sel == dnc_gate_pkg::GATE_FREE);

  ////////////////////////////////////////////////////////////////////////////
  // Issue register
  ////////////////////////////////////////////////////////////////////////////

  // Strobes, one cycle after start
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      issue <= 1'b0;
      error <= 1'b0;
    end else begin
      issue <= start && sel_legal;
      error <= start && !sel_legal;
    end
  end

  // Operand and tag, captured with the start
  always_ff @(posedge CLK) begin
    if (start) begin
      issue_gate <= gate_sel;
      issue_data <= gate_in;
    end
  end

  // A start goes either to the pipeline or to the error output
  // Code 3 is the only selector that ends in error
  a_issue_error_excl : assert property (
    @(posedge CLK) disable iff (!rst_n)
    start |=> ((issue ^ error) && (error == ($past(gate_sel) == 2'd3)))
  );

endmodule

// ==== src/dnc_scalar_logistic.sv ====
`timescale 1ns/1ns

module dnc_scalar_logistic #(
  parameter int DATA_SIZE = 32,
  parameter int FRAC_SIZE = 16
) (
  // Global
  input  logic                   CLK,
  input  logic                   rst_n,

  // From decode
  input  logic                   issue,
  input  dnc_gate_pkg::gate_id_t issue_gate,
  input  logic [DATA_SIZE-1:0]   issue_data,

  // To result
  output logic                   done,
  output dnc_gate_pkg::gate_id_t done_gate,
  output logic [DATA_SIZE-1:0]   done_value
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  // 1.0 in the current format
  localparam logic [DATA_SIZE-1:0] ONE = DATA_SIZE'(1) << FRAC_SIZE;

  // Breakpoints 2.375 = 19/8 and 5
  localparam logic [DATA_SIZE-1:0] BRK_2375 = DATA_SIZE'(19) << (FRAC_SIZE - 3);
  localparam logic [DATA_SIZE-1:0] BRK_5    = DATA_SIZE'(5) << FRAC_SIZE;

  // Segment offsets 0.5, 0.625 = 5/8, 0.84375 = 27/32
  localparam logic [DATA_SIZE-1:0] OFS_0500 = DATA_SIZE'(1) << (FRAC_SIZE - 1);
  localparam logic [DATA_SIZE-1:0] OFS_0625 = DATA_SIZE'(5) << (FRAC_SIZE - 3);
  localparam logic [DATA_SIZE-1:0] OFS_0844 = DATA_SIZE'(27) << (FRAC_SIZE - 5);

  // Segment codes
  localparam logic [1:0] SEG_NEAR = 2'd0;  // |x| < 1
  localparam logic [1:0] SEG_MID  = 2'd1;  // 1 <= |x| < 2.375
  localparam logic [1:0] SEG_FAR  = 2'd2;  // 2.375 <= |x| < 5
  localparam logic [1:0] SEG_SAT  = 2'd3;  // |x| >= 5

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1: sign, magnitude, segment
  ////////////////////////////////////////////////////////////////////////////

  logic                   in_sign;
  logic [DATA_SIZE-1:0]   in_abs;
  logic [1:0]             in_seg;

  logic                   s1_valid;
  dnc_gate_pkg::gate_id_t s1_gate;
  logic                   s1_sign;
  logic [DATA_SIZE-1:0]   s1_abs;
  logic [1:0]             s1_seg;

  // Most negative input stays 2^(N-1) unsigned and lands in saturation
  assign in_sign = issue_data[DATA_SIZE-1];
  assign in_abs  = in_sign ? -issue_data : issue_data;

  // Unsigned compares on the magnitude
  always_comb begin
    if (in_abs >= BRK_5) begin
      in_seg = SEG_SAT;
    end else if (in_abs >= BRK_2375) begin
      in_seg = SEG_FAR;
    end else if (in_abs >= ONE) begin
      in_seg = SEG_MID;
    end else begin
      in_seg = SEG_NEAR;
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
    end
  end

  always_ff @(posedge CLK) begin
    s1_gate <= issue_gate;
    s1_sign <= in_sign;
    s1_abs  <= in_abs;
    s1_seg  <= in_seg;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2: slope and offset
  ////////////////////////////////////////////////////////////////////////////

  logic [DATA_SIZE-1:0]   seg_value;

  logic                   s2_valid;
  dnc_gate_pkg::gate_id_t s2_gate;
  logic                   s2_sign;
  logic [DATA_SIZE-1:0]   s2_value;

  // Magnitude is non-negative so the shift truncates toward zero
  always_comb begin
    case (s1_seg)
      SEG_NEAR: seg_value = (s1_abs >> 2) + OFS_0500;
      SEG_MID:  seg_value = (s1_abs >> 3) + OFS_0625;
      SEG_FAR:  seg_value = (s1_abs >> 5) + OFS_0844;
      default:  seg_value = ONE;
    endcase
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    s2_gate  <= s1_gate;
    s2_sign  <= s1_sign;
    s2_value <= seg_value;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 3: negative mirror
  ////////////////////////////////////////////////////////////////////////////

  // sigmoid(-x) = 1 - sigmoid(x)
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= s2_valid;
    end
  end

  always_ff @(posedge CLK) begin
    done_gate  <= s2_gate;
    done_value <= s2_sign ? (ONE - s2_value) : s2_value;
  end

  // Output of the whole pipeline stays in [0, 1]
  a_value_range : assert property (
    @(posedge CLK) disable iff (!rst_n)
    done |-> (!done_value[DATA_SIZE-1] && (done_value <= ONE))
  );

endmodule

// ==== src/dnc_gate_result.sv ====
`timescale 1ns/1ns

module dnc_gate_result #(
  parameter int DATA_SIZE = 32,
  parameter int FRAC_SIZE = 16
) (
  // Global
  input  logic                   CLK,
  input  logic                   rst_n,

  // From the logistic pipeline
  input  logic                   done,
  input  dnc_gate_pkg::gate_id_t done_gate,
  input  logic [DATA_SIZE-1:0]   done_value,

  // Result strobe
  output logic                   ready,
  output dnc_gate_pkg::gate_id_t gate_id,
  output logic [DATA_SIZE-1:0]   gate_out,

  // Held gate levels for the write logic
  output logic [DATA_SIZE-1:0]   write_gate,
  output logic [DATA_SIZE-1:0]   alloc_gate,
  output logic [DATA_SIZE-1:0]   free_gate
);

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  // Neutral gate value 0.5
  localparam logic [DATA_SIZE-1:0] HALF = DATA_SIZE'(1) << (FRAC_SIZE - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Output strobe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      ready    <= 1'b0;
      gate_id  <= dnc_gate_pkg::GATE_WRITE;
      gate_out <= '0;
    end else begin
      ready <= done;
      // Value and tag hold between results
      if (done) begin
        gate_id  <= done_gate;
        gate_out <= done_value;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Held gates
  ////////////////////////////////////////////////////////////////////////////

  logic [DATA_SIZE-1:0] held [dnc_gate_pkg::GATE_COUNT];

  // Only the tagged register changes, on the same edge as ready
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < dnc_gate_pkg::GATE_COUNT; i++) begin
        held[i] <= HALF;
      end
    end else begin
      for (int i = 0; i < dnc_gate_pkg::GATE_COUNT; i++) begin
        if (done && (done_gate == dnc_gate_pkg::gate_id_t'(i))) begin
          held[i] <= done_value;
        end
      end
    end
  end

  assign write_gate = held[dnc_gate_pkg::GATE_WRITE];
  assign alloc_gate = held[dnc_gate_pkg::GATE_ALLOC];
  assign free_gate  = held[dnc_gate_pkg::GATE_FREE];

  // Named held gate already shows the result in the ready cycle
  a_ready_pulse : assert property (
    @(posedge CLK) disable iff (!rst_n)
    ready |-> (held[gate_id] == gate_out)
  );

endmodule

// ==== src/dnc_gate_unit.sv ====
`timescale 1ns/1ns

module dnc_gate_unit #(
  parameter int DATA_SIZE = dnc_gate_pkg::DEFAULT_DATA_SIZE,
  parameter int FRAC_SIZE = dnc_gate_pkg::DEFAULT_FRAC_SIZE
) (
  // Global
  input  logic                   CLK,
  input  logic                   rst_n,

  // Host issue
  input  logic                   start,
  input  dnc_gate_pkg::gate_id_t gate_sel,
  input  logic [DATA_SIZE-1:0]   gate_in,

  // Result and error strobes
  output logic                   ready,
  output logic                   error,
  output dnc_gate_pkg::gate_id_t gate_id,
  output logic [DATA_SIZE-1:0]   gate_out,

  // Held gate levels
  output logic [DATA_SIZE-1:0]   write_gate,
  output logic [DATA_SIZE-1:0]   alloc_gate,
  output logic [DATA_SIZE-1:0]   free_gate
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Decode to execute
  logic                   issue;
  dnc_gate_pkg::gate_id_t issue_gate;
  logic [DATA_SIZE-1:0]   issue_data;

  // Execute to result
  logic                   done;
  dnc_gate_pkg::gate_id_t done_gate;
  logic [DATA_SIZE-1:0]   done_value;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // g = sigmoid(g^), one cycle decode, three execute, one result
  dnc_gate_decode #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) decode_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .start     (start),
    .gate_sel  (gate_sel),
    .gate_in   (gate_in),
    .issue     (issue),
    .issue_gate(issue_gate),
    .issue_data(issue_data),
    .error     (error)
  );

  dnc_scalar_logistic #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) execute_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .issue     (issue),
    .issue_gate(issue_gate),
    .issue_data(issue_data),
    .done      (done),
    .done_gate (done_gate),
    .done_value(done_value)
  );

  dnc_gate_result #(
    .DATA_SIZE(DATA_SIZE),
    .FRAC_SIZE(FRAC_SIZE)
  ) result_i (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .done      (done),
    .done_gate (done_gate),
    .done_value(done_value),
    .ready     (ready),
    .gate_id   (gate_id),
    .gate_out  (gate_out),
    .write_gate(write_gate),
    .alloc_gate(alloc_gate),
    .free_gate (free_gate)
  );

endmodule

// ==== tb/dnc_gate_clock.sv ====
`timescale 1ns/1ns

module dnc_gate_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic rst_n
);

  // Free-running clock
  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Reset low from time zero, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    rst_n <= 1'b1;
  end

endmodule

// ==== tb/dnc_gate_unit_tb.sv ====
`timescale 1ns/1ns

module dnc_gate_unit_tb;

  localparam int DATA_SIZE = dnc_gate_pkg::DEFAULT_DATA_SIZE;
  localparam int FRAC_SIZE = dnc_gate_pkg::DEFAULT_FRAC_SIZE;
  localparam string PATTERN_FILE = "tb/dnc_gate_patterns.txt";
  localparam int RESET_LIMIT = 40;
  localparam int DRAIN_LIMIT = 40;
  // Neutral gate level 0.5
  localparam logic [DATA_SIZE-1:0] HALF = DATA_SIZE'(1) << (FRAC_SIZE - 1);

  logic                   CLK;
  logic                   rst_n;
  logic                   start;
  dnc_gate_pkg::gate_id_t gate_sel;
  logic [DATA_SIZE-1:0]   gate_in;
  logic                   ready;
  logic                   error;
  dnc_gate_pkg::gate_id_t gate_id;
  logic [DATA_SIZE-1:0]   gate_out;
  logic [DATA_SIZE-1:0]   write_gate;
  logic [DATA_SIZE-1:0]   alloc_gate;
  logic [DATA_SIZE-1:0]   free_gate;

  // Outstanding results, in start order
  int                     rdy_idx[$];
  int                     rdy_due[$];
  dnc_gate_pkg::gate_id_t rdy_sel[$];
  logic [DATA_SIZE-1:0]   rdy_val[$];
  int                     err_idx[$];
  int                     err_due[$];

  // Expected held levels
  logic [DATA_SIZE-1:0] held_model [dnc_gate_pkg::GATE_COUNT];

  int          cyc = 0;
  int          tests_issued = 0;
  int          pass_count = 0;
  int          fail_count = 0;
  int          other_errs = 0;
  bit          timed_out = 1'b0;
  logic [31:0] lfsr = 32'h2fc3;

  dnc_gate_clock clock_i (
    .CLK  (CLK),
    .rst_n(rst_n)
  );

  dnc_gate_unit UUT (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .start     (start),
    .gate_sel  (gate_sel),
    .gate_in   (gate_in),
    .ready     (ready),
    .error     (error),
    .gate_id   (gate_id),
    .gate_out  (gate_out),
    .write_gate(write_gate),
    .alloc_gate(alloc_gate),
    .free_gate (free_gate)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random idle gaps
  ////////////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two bits, one step each, gap 0 to 3
  task automatic draw_gap(output int gap);
    lfsr = lfsr_step(lfsr);
    gap = lfsr[0];
    lfsr = lfsr_step(lfsr);
    gap = gap + 2 * lfsr[0];
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checker, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic record_test(input int idx, input bit ok, input string what);
    if (ok) begin
      pass_count++;
      $display("test %0d (%s): passed", idx, what);
    end else begin
      fail_count++;
      $display("test %0d (%s): FAILED", idx, what);
    end
  endtask

  task automatic check_ready();
    int                     idx;
    int                     due;
    dnc_gate_pkg::gate_id_t sel;
    logic [DATA_SIZE-1:0]   val;
    bit                     ok;
    if (rdy_idx.size() == 0) begin
      $display("At %0t ready pulsed with no legal start outstanding", $time);
      other_errs++;
    end else begin
      idx = rdy_idx.pop_front();
      due = rdy_due.pop_front();
      sel = rdy_sel.pop_front();
      val = rdy_val.pop_front();
      ok = 1'b1;
      if (cyc != due) begin
        $display("CHECK FAILED at %0t: test %0d ready %0d cycles after start, expected 5",
                 $time, idx, cyc - due + 5);
        ok = 1'b0;
      end
      if (gate_id !== sel) begin
        $display("CHECK FAILED at %0t: test %0d gate_id %0d, expected %0d",
                 $time, idx, gate_id, sel);
        ok = 1'b0;
      end
      if (gate_out !== val) begin
        $display("CHECK FAILED at %0t: test %0d gate_out %h, expected %h",
                 $time, idx, gate_out, val);
        ok = 1'b0;
      end
      // Held register follows on the same edge
      held_model[sel] = val;
      record_test(idx, ok, "ready");
    end
  endtask

  task automatic check_error();
    int idx;
    int due;
    bit ok;
    if (err_idx.size() == 0) begin
      $display("At %0t error pulsed with no illegal start outstanding", $time);
      other_errs++;
    end else begin
      idx = err_idx.pop_front();
      due = err_due.pop_front();
      ok = (cyc == due);
      if (!ok) begin
        $display("CHECK FAILED at %0t: test %0d error %0d cycles after start, expected 1",
                 $time, idx, cyc - due + 1);
      end
      record_test(idx, ok, "error");
    end
  endtask

  // Only the named gate may ever change
  task automatic check_held();
    if (write_gate !== held_model[dnc_gate_pkg::GATE_WRITE] ||
        alloc_gate !== held_model[dnc_gate_pkg::GATE_ALLOC] ||
        free_gate  !== held_model[dnc_gate_pkg::GATE_FREE]) begin
      $display("CHECK FAILED at %0t: held gates %h %h %h, expected %h %h %h",
               $time, write_gate, alloc_gate, free_gate,
               held_model[0], held_model[1], held_model[2]);
      other_errs++;
    end
  endtask

  always @(negedge CLK) begin
    cyc = cyc + 1;
    if (rst_n === 1'b1) begin
      if (ready) check_ready();
      if (error) check_error();
      check_held();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_reset();
    int waited;
    waited = 0;
    while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
      @(posedge CLK);
      waited++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timeout: reset was never released");
      timed_out = 1'b1;
    end
  endtask

  // Strobes and result value come out of reset at zero
  task automatic check_reset_state();
    @(negedge CLK);
    if (ready !== 1'b0 || error !== 1'b0 || gate_out !== '0) begin
      $display("CHECK FAILED at %0t: after reset ready %b error %b gate_out %h",
               $time, ready, error, gate_out);
      other_errs++;
    end
  endtask

  task automatic issue_start(input int idx, input logic [31:0] sel_w,
                             input logic [DATA_SIZE-1:0] din,
                             input logic [DATA_SIZE-1:0] val, input logic [31:0] errf);
    @(posedge CLK);
    start    <= 1'b1;
    gate_sel <= sel_w[1:0];
    gate_in  <= din;
    // Start is seen high at falling edge cyc + 1
    if (errf != 0) begin
      err_idx.push_back(idx);
      err_due.push_back(cyc + 2);
    end else begin
      rdy_idx.push_back(idx);
      rdy_due.push_back(cyc + 6);
      rdy_sel.push_back(sel_w[1:0]);
      rdy_val.push_back(val);
    end
  endtask

  task automatic drive_patterns();
    int                   fd;
    int                   n;
    int                   r;
    int                   gap;
    string                line;
    logic [31:0]          sel_w;
    logic [31:0]          errf;
    logic [DATA_SIZE-1:0] din;
    logic [DATA_SIZE-1:0] val;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open pattern file %s", PATTERN_FILE);
      other_errs++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // Skip comments and blank lines
        if (n > 0 && line.len() > 0 && line[0] != "#") begin
          r = $sscanf(line, "%h %h %h %h", sel_w, din, val, errf);
          if (r == 4) begin
            draw_gap(gap);
            for (int i = 0; i < gap; i++) begin
              @(posedge CLK);
              start <= 1'b0;
            end
            tests_issued++;
            issue_start(tests_issued, sel_w, din, val, errf);
          end else if (r > 0) begin
            $display("Malformed pattern line: %s", line);
            other_errs++;
          end
        end
      end
      $fclose(fd);
    end
    @(posedge CLK);
    start <= 1'b0;
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while ((rdy_idx.size() != 0 || err_idx.size() != 0) && waited < DRAIN_LIMIT) begin
      @(posedge CLK);
      waited++;
    end
    if (rdy_idx.size() != 0 || err_idx.size() != 0) begin
      $display("Timeout: %0d results never arrived", rdy_idx.size() + err_idx.size());
      timed_out = 1'b1;
    end else begin
      // Quiet period catches stray pulses
      repeat (8) @(posedge CLK);
    end
  endtask

  initial begin
    start    = 1'b0;
    gate_sel = dnc_gate_pkg::GATE_WRITE;
    gate_in  = '0;
    for (int i = 0; i < dnc_gate_pkg::GATE_COUNT; i++) begin
      held_model[i] = HALF;
    end
    wait_reset();
    if (!timed_out) begin
      check_reset_state();
      drive_patterns();
      drain_results();
    end
    if (tests_issued == 0) begin
      $display("No tests were read from the pattern file");
      other_errs++;
    end
    $display("tests passed %0d, failed %0d, other errors %0d",
             pass_count, fail_count, other_errs);
    if (!timed_out && fail_count == 0 && other_errs == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tb/dnc_gate_patterns.txt ====
# Columns, all hex: selector, input Q15.16, expected gate value, expected error flag
# Format 32 bits with 16 fraction bits, 1.0 = 00010000
# |x| < 1
0 00000000 00008000 0
1 00004000 00009000 0
2 FFFFC000 00007000 0
0 0000FFFF 0000BFFF 0
1 00000003 00008000 0
2 FFFFFFFD 00008000 0
0 FFFF0001 00004001 0
2 00008000 0000A000 0
1 FFFF8000 00006000 0
# 1 <= |x| < 2.375
0 00010000 0000C000 0
1 00018000 0000D000 0
2 FFFE8000 00003000 0
0 00025FFF 0000EBFF 0
1 FFFF0000 00004000 0
2 00010007 0000C000 0
0 00020000 0000E000 0
# 2.375 <= |x| < 5
0 00026000 0000EB00 0
1 00030000 0000F000 0
2 FFFD0000 00001000 0
0 0004FFFF 0000FFFF 0
1 FFFB0001 00000001 0
2 0004001F 0000F800 0
# Saturation at and beyond 5
0 00050000 00010000 0
1 FFFB0000 00000000 0
2 7FFFFFFF 00010000 0
0 80000000 00000000 0
1 00640000 00010000 0
# Illegal selector
3 00018000 00000000 1
3 FFFF0000 00000000 1
2 00008000 0000A000 0
3 00000000 00000000 1
1 FFFF8000 00006000 0
0 00020000 0000E000 0

// ==== dnc_gate_unit.f ====
src/dnc_gate_pkg.sv
src/dnc_gate_decode.sv
src/dnc_scalar_logistic.sv
src/dnc_gate_result.sv
src/dnc_gate_unit.sv
tb/dnc_gate_clock.sv
tb/dnc_gate_unit_tb.sv
